/* design/regmgr_pkg.sv */
`default_nettype none

package regmgr_pkg;

  // data word and memory address
  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;

  // register number, offset from the process base
  typedef logic [3:0] reg_num_t;

  // register operations issued by the control side
  typedef enum logic [2:0] {
    op_idle      = 3'd0,
    op_catch     = 3'd1,
    op_prepare   = 3'd2,
    op_read      = 3'd3,
    op_read_ptr  = 3'd4,
    op_write     = 3'd5,
    op_write_ptr = 3'd6
  } reg_op_e;

  // post-modification applied on write
  typedef enum logic [1:0] {
    step_none = 2'd0,
    step_inc  = 2'd1,
    step_dec  = 2'd2
  } step_e;

  // operation request, held by the control side until next_state
  typedef struct packed {
    reg_op_e  op;
    reg_num_t reg_num;
    // register is used as a pointer
    logic     is_ptr;
    step_e    step;
    // process base address
    addr_t    base;
  } reg_ctrl_t;

  // bus request strobes, address and data are zero outside the strobe
  typedef struct packed {
    logic  rd_q;
    logic  wr_q;
    addr_t addr;
    data_t data;
  } bus_req_t;

  // bus completion, address is echoed back
  typedef struct packed {
    logic  busy;
    logic  rd_dn;
    logic  wr_dn;
    addr_t addr;
    data_t data;
  } bus_rsp_t;

  // outstanding request, as seen by the completion tracker
  typedef struct packed {
    logic  valid;
    logic  is_write;
    addr_t addr;
  } pending_t;

endpackage

`default_nettype wire

/* design/reg_bus_requester.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_bus_requester
  import regmgr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_ctrl_t ctrl,
  input  data_t     pointer,
  input  data_t     save_data,
  input  logic      done,
  output bus_req_t  bus_req,
  output pending_t  pend
);

  // arm: waiting for a memory op
  // strobe: request on the bus this cycle
  // wait: request pending until the tracker signals done
  typedef enum logic [1:0] {
    st_arm,
    st_strobe,
    st_wait
  } req_state_e;

  req_state_e state;

  // skip one cycle after done, op is still held while next_state pulses
  logic hold;

  logic  is_rd;
  logic  is_wr;
  logic  use_ptr;
  addr_t req_addr;

  // op decode
  assign is_rd   = (ctrl.op == op_read) || (ctrl.op == op_read_ptr);
  assign is_wr   = (ctrl.op == op_write) || (ctrl.op == op_write_ptr);
  assign use_ptr = (ctrl.op == op_read_ptr) || (ctrl.op == op_write_ptr);

  // pointer ops address through the pointer copy, others by register number
  assign req_addr = ctrl.base + (use_ptr ? pointer : addr_t'(ctrl.reg_num));

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_arm;
      hold    <= 1'b0;
      bus_req <= '0;
      pend    <= '0;
    end else begin
      case (state)
        st_arm: begin
          if (hold) begin
            hold <= 1'b0;
          end else if (is_rd || is_wr) begin
            // write data only travels with a write strobe
            bus_req <= '{rd_q: is_rd,
                         wr_q: is_wr,
                         addr: req_addr,
                         data: is_wr ? save_data : '0};
            pend    <= '{valid: 1'b1, is_write: is_wr, addr: req_addr};
            state   <= st_strobe;
          end
        end
        st_strobe: begin
          // strobe lasts one cycle
          bus_req <= '0;
          if (done) begin
            pend  <= '0;
            hold  <= 1'b1;
            state <= st_arm;
          end else begin
            state <= st_wait;
          end
        end
        st_wait: begin
          // mismatched or late completions just keep us here
          if (done) begin
            pend  <= '0;
            hold  <= 1'b1;
            state <= st_arm;
          end
        end
        default: begin
          state <= st_arm;
        end
      endcase
    end
  end

  // one strobe kind at a time, never two cycles long
  a_strobe_single: assert property (
    @(posedge clk) disable iff (rst)
    (bus_req.rd_q || bus_req.wr_q) |->
      !(bus_req.rd_q && bus_req.wr_q) ##1 !(bus_req.rd_q || bus_req.wr_q)
  );

endmodule

`default_nettype wire

/* design/reg_operand_store.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_operand_store
  import regmgr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_ctrl_t ctrl,
  input  data_t     catch_data,
  input  data_t     bus_data,
  input  logic      load,
  output data_t     operand,
  output data_t     pointer,
  output data_t     save_data
);

  // catch already taken for this op
  // toggles, so back-to-back catches each load once
  logic caught;

  // operand or pointer, before post-modification
  data_t chosen;

  always_ff @(posedge clk) begin
    if (rst) begin
      operand <= '0;
      pointer <= '0;
      caught  <= 1'b0;
    end else begin
      // value from the ALU side, operand only
      if (ctrl.op == op_catch) begin
        if (!caught) begin
          operand <= catch_data;
        end
        caught <= !caught;
      end else begin
        caught <= 1'b0;
      end

      // read response
      if (load) begin
        case (ctrl.op)
          op_read: begin
            // register word doubles as the pointer copy
            operand <= bus_data;
            pointer <= bus_data;
          end
          op_read_ptr: begin
            operand <= bus_data;
          end
          default: begin
            operand <= operand;
          end
        endcase
      end
    end
  end

  // save value
  always_comb begin
    chosen = operand;
    if ((ctrl.op == op_write) && ctrl.is_ptr) begin
      chosen = pointer;
    end
    save_data = chosen;
    // step only applies to plain write, write_ptr stores operand as is
    if (ctrl.op == op_write) begin
      case (ctrl.step)
        step_inc: save_data = chosen + 32'd1;
        step_dec: save_data = chosen - 32'd1;
        default:  save_data = chosen;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/reg_completion_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_completion_tracker
  import regmgr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_ctrl_t ctrl,
  input  pending_t  pend,
  input  bus_rsp_t  bus_rsp,
  output logic      done,
  output logic      load,
  output logic      next_state
);

  logic kind_ok;
  logic match;
  logic ack_op;

  // acknowledge already given for the current catch or prepare
  logic seen;

  // strobe kind must fit the pending request
  assign kind_ok = pend.is_write ? bus_rsp.wr_dn : bus_rsp.rd_dn;

  // completion for us, wrong echoed address is someone else's
  assign match = pend.valid && bus_rsp.busy && kind_ok && (bus_rsp.addr == pend.addr);

  assign done = match;
  // only reads carry data back
  assign load = match && !pend.is_write;

  // ops that finish without the bus
  assign ack_op = (ctrl.op == op_catch) || (ctrl.op == op_prepare);

  always_ff @(posedge clk) begin
    if (rst) begin
      next_state <= 1'b0;
      seen       <= 1'b0;
    end else begin
      // one cycle after match or after an ack op first appears
      next_state <= match || (ack_op && !seen);
      // op is still held during the pulse, skip that cycle
      if (ack_op) begin
        seen <= !seen;
      end else begin
        seen <= 1'b0;
      end
    end
  end

  // next_state is a single-cycle pulse
  a_next_state_pulse: assert property (
    @(posedge clk) disable iff (rst)
    next_state |=> !next_state
  );

endmodule

`default_nettype wire

/* design/regmgr_top.sv */
`timescale 1ns/1ns
`default_nettype none

module regmgr_top
  import regmgr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_ctrl_t ctrl,
  input  data_t     catch_data,
  input  bus_rsp_t  bus_rsp,
  output bus_req_t  bus_req,
  output logic      next_state,
  output data_t     operand,
  output data_t     pointer
);

  // request outstanding
  pending_t pend;

  // completion strobes from the tracker
  logic done;
  logic load;

  // value to store on write
  data_t save_data;

  // issues strobes, keeps the pending address
  reg_bus_requester u_requester (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .pointer   (pointer),
    .save_data (save_data),
    .done      (done),
    .bus_req   (bus_req),
    .pend      (pend)
  );

  // operand and pointer registers
  reg_operand_store u_store (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .catch_data (catch_data),
    .bus_data   (bus_rsp.data),
    .load       (load),
    .operand    (operand),
    .pointer    (pointer),
    .save_data  (save_data)
  );

  // matches completions, raises next_state
  reg_completion_tracker u_tracker (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .pend       (pend),
    .bus_rsp    (bus_rsp),
    .done       (done),
    .load       (load),
    .next_state (next_state)
  );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic rst
);

  // free-running clock
  initial begin
    clk = 1'b0;
    forever begin
      #half_period clk = ~clk;
    end
  end

  // reset held for a fixed number of rising edges, released just after one
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* verification/regmgr_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module regmgr_tb
  import regmgr_pkg::*;
();

  localparam int half_period    = 10;
  localparam int reset_cycles   = 10;
  // watchdog budget per vector
  localparam int cycles_per_vec = 40;
  localparam int max_vecs       = 64;

  // one vector line of the tests file
  typedef struct packed {
    reg_ctrl_t ctrl;
    data_t     catch_data;
    data_t     exp_operand;
    data_t     exp_pointer;
    addr_t     exp_waddr;
    data_t     exp_wdata;
    // inject a completion with a wrong address first
    logic      bad;
  } vec_t;

  logic      clk;
  logic      rst;
  reg_ctrl_t ctrl;
  data_t     catch_data;
  bus_rsp_t  bus_rsp;
  bus_req_t  bus_req;
  logic      next_state;
  data_t     operand;
  data_t     pointer;

  // bus memory indexed by the low address byte
  data_t  mem [0:255];
  // full address last stored in each word
  addr_t  word_addr [0:255];
  vec_t   vecs [0:max_vecs-1];
  int     n_vec = 0;
  logic   loaded = 1'b0;
  int     errors = 0;
  int     vec_idx = 0;
  integer seed = 37;

  // bus model bookkeeping
  logic  inject_bad = 1'b0;
  int    strobe_count = 0;
  int    write_count = 0;
  int    rsp_count = 0;
  addr_t last_waddr = '0;
  data_t last_wdata = '0;

  tb_clock_gen #(
    .half_period  (half_period),
    .reset_cycles (reset_cycles)
  ) u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  regmgr_top DUT (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .catch_data (catch_data),
    .bus_rsp    (bus_rsp),
    .bus_req    (bus_req),
    .next_state (next_state),
    .operand    (operand),
    .pointer    (pointer)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h (vector %0d)",
               name, got, exp, vec_idx);
    end
  endtask

  // words never stored at this exact address return a pattern of the whole address
  function automatic data_t read_word(input addr_t a);
    data_t d;
    if (word_addr[a[7:0]] == a) begin
      d = mem[a[7:0]];
    end else begin
      d = a ^ 32'hf1f1_f1f1;
    end
    return d;
  endfunction

  // preload lines go to memory, vector lines to vecs
  task automatic load_tests();
    integer           fd;
    integer           r;
    logic [7:0]       tag;
    logic [8*256-1:0] line;
    logic [31:0]      col [0:10];
    addr_t            a;
    data_t            d;
    vec_t             nv;
    fd = $fopen("verification/regmgr_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/regmgr_tests.txt");
      errors++;
      return;
    end
    tag = '0;
    r = $fscanf(fd, "%s", tag);
    while (r == 1) begin
      if (tag == "#") begin
        r = $fgets(line, fd);
      end else if (tag == "m") begin
        r = $fscanf(fd, "%h %h", a, d);
        mem[a[7:0]]       = d;
        word_addr[a[7:0]] = a;
      end else if (tag == "v") begin
        r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                    col[3], col[4], col[5], col[6], col[7], col[8], col[9], col[10]);
        if ((r != 11) || (n_vec >= max_vecs)) begin
          $display("malformed or surplus vector line after vector %0d", n_vec);
          errors++;
        end else begin
          nv.ctrl.op      = reg_op_e'(col[0][2:0]);
          nv.ctrl.reg_num = col[1][3:0];
          nv.ctrl.is_ptr  = col[2][0];
          nv.ctrl.step    = step_e'(col[3][1:0]);
          nv.ctrl.base    = col[4];
          nv.catch_data   = col[5];
          nv.exp_operand  = col[6];
          nv.exp_pointer  = col[7];
          nv.exp_waddr    = col[8];
          nv.exp_wdata    = col[9];
          nv.bad          = col[10][0];
          vecs[n_vec]     = nv;
          n_vec++;
        end
      end else begin
        $display("unknown line in tests file after vector %0d", n_vec);
        errors++;
        r = $fgets(line, fd);
      end
      tag = '0;
      r = $fscanf(fd, "%s", tag);
    end
    $fclose(fd);
  endtask

  // one op from drive to next_state and its checks
  task automatic run_vector(input int idx);
    vec_t v;
    int   cycles;
    int   strobes_before;
    int   writes_before;
    int   rsps_before;
    logic is_ack;
    logic is_wr;
    v = vecs[idx];
    vec_idx = idx;
    is_ack = (v.ctrl.op == op_catch) || (v.ctrl.op == op_prepare);
    is_wr = (v.ctrl.op == op_write) || (v.ctrl.op == op_write_ptr);
    strobes_before = strobe_count;
    writes_before = write_count;
    rsps_before = rsp_count;
    @(posedge clk);
    #2;
    ctrl       = v.ctrl;
    catch_data = v.catch_data;
    inject_bad = v.bad;
    cycles = 0;
    // first cycle must be quiet, which also shows the last pulse was single
    do begin
      @(negedge clk);
      cycles++;
      if (next_state && (cycles == 1)) begin
        $display("vector %0d: next_state high in the first cycle of the op", idx);
        errors++;
      end
    end while (!(next_state && (cycles > 1)));
    check_value("operand", operand, v.exp_operand);
    check_value("pointer", pointer, v.exp_pointer);
    if (is_ack) begin
      if (cycles != 2) begin
        $display("vector %0d: acknowledge came %0d cycles after the op, not 1",
                 idx, cycles - 1);
        errors++;
      end
      if (strobe_count != strobes_before) begin
        $display("vector %0d: catch or prepare put a request on the bus", idx);
        errors++;
      end
    end else begin
      if (strobe_count != strobes_before + 1) begin
        $display("vector %0d: expected one bus request, saw %0d", idx,
                 strobe_count - strobes_before);
        errors++;
      end
      // a pulse before the real completion means a wrong address was taken
      if (rsp_count != rsps_before + 1) begin
        $display("vector %0d: next_state before the matching completion", idx);
        errors++;
      end
      if (is_wr) begin
        check_value("bus_req.addr", last_waddr, v.exp_waddr);
        check_value("bus_req.data", last_wdata, v.exp_wdata);
      end else if (write_count != writes_before) begin
        $display("vector %0d: read op wrote to memory", idx);
        errors++;
      end
    end
  endtask

  // bus model answering each strobe after 0 to 5 cycles
  initial begin : bus_model
    int    delay;
    logic  is_rd;
    addr_t a;
    bus_rsp = '0;
    forever begin
      @(negedge clk);
      if (bus_req.rd_q || bus_req.wr_q) begin
        strobe_count++;
        is_rd = bus_req.rd_q;
        a = bus_req.addr;
        if (bus_req.wr_q) begin
          write_count++;
          last_waddr = a;
          last_wdata = bus_req.data;
          mem[a[7:0]] = bus_req.data;
          word_addr[a[7:0]] = a;
        end
        delay = $unsigned($random(seed)) % 6;
        if (inject_bad) begin
          // same kind but a foreign address
          @(posedge clk);
          #2;
          bus_rsp = '{busy: 1'b1, rd_dn: is_rd, wr_dn: !is_rd,
                      addr: a ^ 32'h0000_0010, data: 32'hdead_beef};
          @(posedge clk);
          #2;
          bus_rsp = '0;
        end
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #2;
        bus_rsp = '{busy: 1'b1, rd_dn: is_rd, wr_dn: !is_rd,
                    addr: a, data: is_rd ? read_word(a) : '0};
        rsp_count++;
        @(posedge clk);
        #2;
        bus_rsp = '0;
      end
    end
  end

  initial begin : main
    ctrl       = '0;
    catch_data = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i]       = '0;
      word_addr[i] = '1;
    end
    load_tests();
    if ((errors == 0) && (n_vec == 0)) begin
      $display("tests file holds no vectors");
      errors++;
    end
    if (errors == 0) begin
      loaded = 1'b1;
      wait (rst === 1'b1);
      wait (rst === 1'b0);
      for (int i = 0; i < n_vec; i++) begin
        run_vector(i);
      end
      // back to idle
      @(posedge clk);
      #2;
      ctrl = '0;
      repeat (4) @(posedge clk);
    end
    $display("errors: %0d in %0d vectors", errors, n_vec);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // run length scales with the vector count
  initial begin : watchdog
    wait (loaded === 1'b1);
    repeat (reset_cycles + (n_vec + 1) * cycles_per_vec) @(posedge clk);
    $display("timeout: run did not end within %0d cycles",
             reset_cycles + (n_vec + 1) * cycles_per_vec);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/regmgr_tests.txt */
# m: address data, preload of the bus memory (low address byte selects the word)
# v: op reg_num is_ptr step base catch_data exp_operand exp_pointer exp_waddr exp_wdata bad
# op 1 catch 2 prepare 3 read 4 read_ptr 5 write 6 write_ptr, step 0 none 1 inc 2 dec
m 00000103 00000040
m 00000140 12345678
m 00000105 000000a0
m 000001a0 cafef00d
m 00000201 00000021
m 00000221 5eed0021
# read, read_ptr, write with inc and dec
v 3 3 0 0 00000100 00000000 00000040 00000040 00000000 00000000 0
v 4 0 0 0 00000100 00000000 12345678 00000040 00000000 00000000 0
v 5 8 0 1 00000100 00000000 12345678 00000040 00000108 12345679 0
v 5 9 1 2 00000100 00000000 12345678 00000040 00000109 0000003f 0
# catch, prepare, write_ptr ignores its step
v 1 0 0 0 00000100 a5a5a5a5 a5a5a5a5 00000040 00000000 00000000 0
v 2 0 0 0 00000100 11111111 a5a5a5a5 00000040 00000000 00000000 0
v 6 0 0 1 00000100 00000000 a5a5a5a5 00000040 00000140 a5a5a5a5 0
# wrong echoed address first
v 3 5 0 0 00000100 00000000 000000a0 000000a0 00000000 00000000 1
v 4 0 0 0 00000100 00000000 cafef00d 000000a0 00000000 00000000 1
v 5 7 0 0 00000100 00000000 cafef00d 000000a0 00000107 cafef00d 1
v 3 7 0 0 00000100 00000000 cafef00d cafef00d 00000000 00000000 0
# back-to-back catches, carry across bit 31
v 1 0 0 0 00000100 00000000 00000000 cafef00d 00000000 00000000 0
v 1 0 0 0 00000100 7fffffff 7fffffff cafef00d 00000000 00000000 0
v 5 2 0 1 00000100 00000000 7fffffff cafef00d 00000102 80000000 0
v 5 4 1 2 00000100 00000000 7fffffff cafef00d 00000104 cafef00c 0
# second process base
v 3 1 0 0 00000200 00000000 00000021 00000021 00000000 00000000 0
v 4 0 0 0 00000200 00000000 5eed0021 00000021 00000000 00000000 0
v 6 0 0 2 00000200 00000000 5eed0021 00000021 00000221 5eed0021 1
v 2 0 0 0 00000200 deadbeef 5eed0021 00000021 00000000 00000000 0
v 5 0 0 2 00000100 00000000 5eed0021 00000021 00000100 5eed0020 0
# wrap on dec and inc
v 1 0 0 0 00000100 00000000 00000000 00000021 00000000 00000000 0
v 5 6 0 2 00000100 00000000 00000000 00000021 00000106 ffffffff 0
v 3 6 0 0 00000100 00000000 ffffffff ffffffff 00000000 00000000 0
v 5 a 1 1 00000100 00000000 ffffffff ffffffff 0000010a 00000000 1

/* regmgr.f */
design/regmgr_pkg.sv
design/reg_bus_requester.sv
design/reg_operand_store.sv
design/reg_completion_tracker.sv
design/regmgr_top.sv
verification/tb_clock_gen.sv
verification/regmgr_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the register manager testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module regmgr_tb -f regmgr.f -o regmgr_sim \
  && ./obj_dir/regmgr_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see sim.log"; exit 1; }
# result is taken from the log
grep -qx "Test passed" sim.log \
  && echo "simulation ok" \
  || { echo "simulation reported errors, see sim.log"; exit 1; }
